//--- Makefile
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vaes256_enc_tb: tb.f $(wildcard logic/*.sv verif/*.sv)
	verilator --binary --timing -Wno-fatal -f tb.f --top-module aes256_enc_tb -o Vaes256_enc_tb

run: obj_dir/Vaes256_enc_tb
	./obj_dir/Vaes256_enc_tb 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module aes256_enc

clean:
	rm -rf obj_dir $(LOG)

//--- logic/aes256_enc.sv
`timescale 1ns/1ps
`default_nettype none

module aes256_enc
(
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      wr_en,
    input  wire aes_host_pkg::host_addr_t  addr,
    input  wire aes_host_pkg::flag_pos_t   pos,
    input  wire logic                      flag_val,
    input  wire aes_pkg::aes_block_t       wdata,
    output aes_pkg::aes_block_t            ciphertext,
    output logic                           done,
    output logic                           busy,
    output logic                           irq,
    output aes_host_pkg::ctrl_flags_t      flags
);

    aes_host_pkg::host_cmd_t  cmd;
    aes_host_pkg::exec_req_t  req;
    aes_host_pkg::exec_rsp_t  rsp;

    // Host write bundle
    assign cmd = '{wr_en: wr_en, addr: addr, pos: pos, flag_val: flag_val, wdata: wdata};

    aes_cmd_decode u_cmd_decode
    (
        .clk   (clk),
        .rst   (rst),
        .cmd   (cmd),
        .busy  (busy),
        .req   (req),
        .flags (flags)
    );

    aes_round_exec u_round_exec
    (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .busy (busy),
        .rsp  (rsp)
    );

    aes_result_reg u_result_reg
    (
        .clk        (clk),
        .rst        (rst),
        .start      (req.start),
        .rsp        (rsp),
        .irq_en     (flags[aes_host_pkg::FLAG_IRQ_EN]),
        .ciphertext (ciphertext),
        .done       (done),
        .irq        (irq)
    );

endmodule

`default_nettype wire

//--- logic/aes_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module aes_cmd_decode
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire aes_host_pkg::host_cmd_t  cmd,
    input  wire logic                     busy,
    output aes_host_pkg::exec_req_t       req,
    output aes_host_pkg::ctrl_flags_t     flags
);

    aes_host_pkg::ctrl_flags_t  flags_q;
    aes_pkg::aes_key_t          key_q;
    logic                       start_q;
    aes_pkg::aes_block_t        block_q;
    aes_pkg::aes_key_t          req_key_q;
    logic                       accept;

    // A start needs the enable flag and an idle core
    // start_q covers the cycle before busy rises
    assign accept = cmd.wr_en && (cmd.addr == aes_host_pkg::ADDR_PLAIN) &&
                    flags_q[aes_host_pkg::FLAG_ENABLE] && !busy && !start_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            flags_q <= '0;
            key_q   <= '0;
            start_q <= 1'b0;
        end
        else
        begin
            start_q <= accept;
            if (cmd.wr_en && (cmd.addr == aes_host_pkg::ADDR_FLAGS) &&
                (cmd.pos < aes_host_pkg::FLAG_COUNT))
                flags_q[cmd.pos] <= cmd.flag_val;
            if (cmd.wr_en && (cmd.addr == aes_host_pkg::ADDR_KEY_LO))
                key_q[127:0] <= cmd.wdata;
            if (cmd.wr_en && (cmd.addr == aes_host_pkg::ADDR_KEY_HI))
                key_q[255:128] <= cmd.wdata;
        end
    end

    // Snapshot of plaintext and key that goes out with the strobe
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            block_q   <= cmd.wdata;
            req_key_q <= key_q;
        end
    end

    assign req.start = start_q;
    assign req.block = block_q;
    assign req.key   = req_key_q;
    assign flags     = flags_q;

endmodule

`default_nettype wire

//--- logic/aes_host_pkg.sv
`default_nettype none

package aes_host_pkg;

    typedef enum logic [1:0]
    {
        ADDR_FLAGS  = 2'd0,
        ADDR_PLAIN  = 2'd1,
        ADDR_KEY_LO = 2'd2,
        ADDR_KEY_HI = 2'd3
    } host_addr_t;

    localparam int FLAG_COUNT = 5;

    typedef logic [2:0]            flag_pos_t;
    typedef logic [FLAG_COUNT-1:0] ctrl_flags_t;

    // Flags 2 to 4 are plain storage
    localparam flag_pos_t FLAG_ENABLE = 3'd0;
    localparam flag_pos_t FLAG_IRQ_EN = 3'd1;

    typedef struct packed
    {
        logic                 wr_en;
        host_addr_t           addr;
        flag_pos_t            pos;
        logic                 flag_val;
        aes_pkg::aes_block_t  wdata;
    } host_cmd_t;

    typedef struct packed
    {
        logic                 start;
        aes_pkg::aes_block_t  block;
        aes_pkg::aes_key_t    key;
    } exec_req_t;

    typedef struct packed
    {
        logic                 done;
        aes_pkg::aes_block_t  block;
    } exec_rsp_t;

endpackage

`default_nettype wire

//--- logic/aes_key_expand.sv
`timescale 1ns/1ps
`default_nettype none

module aes_key_expand
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 load,
    input  wire aes_pkg::aes_key_t    key,
    input  wire logic                 step,
    input  wire aes_pkg::round_idx_t  round,
    output aes_pkg::aes_block_t       round_key
);

    // Window holds words w[i-8] .. w[i-1], oldest word in the top bits
    aes_pkg::aes_key_t   win;
    aes_pkg::aes_word_t  t;
    aes_pkg::aes_word_t  n0;
    aes_pkg::aes_word_t  n1;
    aes_pkg::aes_word_t  n2;
    aes_pkg::aes_word_t  n3;
    aes_pkg::round_idx_t rcon_idx;
    aes_pkg::aes_byte_t  rcon;

    function automatic aes_pkg::aes_word_t sub_word(input aes_pkg::aes_word_t w);
        return {aes_pkg::sbox(w[31:24]), aes_pkg::sbox(w[23:16]),
                aes_pkg::sbox(w[15:8]),  aes_pkg::sbox(w[7:0])};
    endfunction

    // Odd rounds produce a word index that is a multiple of 8
    assign rcon_idx = (round + 4'd1) >> 1;
    assign rcon     = 8'h01 << (rcon_idx - 4'd1);

    always_comb
    begin
        if (round[0])
            t = sub_word({win[23:0], win[31:24]}) ^ {rcon, 24'h000000};
        else
            t = sub_word(win[31:0]);
        n0 = win[255:224] ^ t;
        n1 = win[223:192] ^ n0;
        n2 = win[191:160] ^ n1;
        n3 = win[159:128] ^ n2;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            win <= '0;
        else if (load)
            win <= key;
        else if (step)
            win <= {win[127:0], n0, n1, n2, n3};
    end

    // Newest four words are the key of the round in progress
    assign round_key = win[127:0];

endmodule

`default_nettype wire

//--- logic/aes_pkg.sv
`default_nettype none

package aes_pkg;

    typedef logic [7:0]   aes_byte_t;
    typedef logic [31:0]  aes_word_t;
    typedef logic [127:0] aes_block_t;
    typedef logic [255:0] aes_key_t;
    typedef logic [3:0]   round_idx_t;
    typedef logic [3:0]   byte_idx_t;

    // AES-256 round count
    localparam round_idx_t AES_ROUNDS = 4'd14;

    // Forward S-box, row 0 in the top bits
    localparam logic [2047:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // Byte b sits at bit offset (255 - b) * 8
    function automatic aes_byte_t sbox(input aes_byte_t b);
        return SBOX_TABLE[{~b, 3'b000} +: 8];
    endfunction

endpackage

`default_nettype wire

//--- logic/aes_result_reg.sv
`timescale 1ns/1ps
`default_nettype none

module aes_result_reg
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     start,
    input  wire aes_host_pkg::exec_rsp_t  rsp,
    input  wire logic                     irq_en,
    output aes_pkg::aes_block_t           ciphertext,
    output logic                          done,
    output logic                          irq
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ciphertext <= '0;
            done       <= 1'b0;
            irq        <= 1'b0;
        end
        else
        begin
            // irq lasts one cycle, done stays until the next start
            irq <= 1'b0;
            if (rsp.done)
            begin
                ciphertext <= rsp.block;
                done       <= 1'b1;
                irq        <= irq_en;
            end
            else if (start)
                done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/aes_round_exec.sv
`timescale 1ns/1ps
`default_nettype none

module aes_round_exec
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire aes_host_pkg::exec_req_t  req,
    output logic                          busy,
    output aes_host_pkg::exec_rsp_t       rsp
);

    typedef enum logic [1:0]
    {
        IDLE = 2'd0,
        SUB  = 2'd1,
        MIX  = 2'd2
    } exec_state_t;

    exec_state_t          fsm;
    aes_pkg::aes_block_t  blk;
    aes_pkg::byte_idx_t   cnt;
    aes_pkg::round_idx_t  round_q;
    logic                 done_q;
    aes_pkg::aes_block_t  round_key;
    aes_pkg::aes_block_t  shifted;
    aes_pkg::aes_block_t  mixed;
    aes_pkg::aes_block_t  mix_out;
    logic                 key_load;
    logic                 key_step;

    function automatic aes_pkg::aes_byte_t xtime(input aes_pkg::aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_pkg::aes_word_t mix_column(input aes_pkg::aes_word_t w);
        aes_pkg::aes_byte_t a0;
        aes_pkg::aes_byte_t a1;
        aes_pkg::aes_byte_t a2;
        aes_pkg::aes_byte_t a3;
        a0 = w[31:24];
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        // 3x is xtime(x) ^ x
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // Byte 4c+r holds row r, column c; row r rotates left by r
    function automatic aes_pkg::aes_block_t shift_rows(input aes_pkg::aes_block_t s);
        aes_pkg::aes_block_t o;
        int c;
        int r;
        o = '0;
        for (c = 0; c < 4; c++)
        begin
            for (r = 0; r < 4; r++)
                o[127 - 8*(4*c + r) -: 8] = s[127 - 8*(4*((c + r) % 4) + r) -: 8];
        end
        return o;
    endfunction

    always_comb
    begin
        shifted = shift_rows(blk);
        mixed   = {mix_column(shifted[127:96]), mix_column(shifted[95:64]),
                   mix_column(shifted[63:32]),  mix_column(shifted[31:0])};
        // Final round has no MixColumns
        if (round_q == aes_pkg::AES_ROUNDS)
            mix_out = shifted ^ round_key;
        else
            mix_out = mixed ^ round_key;
    end

    assign key_load = (fsm == IDLE) && req.start;
    assign key_step = (fsm == MIX);

    aes_key_expand u_key_expand
    (
        .clk       (clk),
        .rst       (rst),
        .load      (key_load),
        .key       (req.key),
        .step      (key_step),
        .round     (round_q),
        .round_key (round_key)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fsm     <= IDLE;
            cnt     <= '0;
            round_q <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (fsm)
                IDLE:
                begin
                    if (req.start)
                    begin
                        round_q <= 4'd1;
                        cnt     <= '0;
                        fsm     <= SUB;
                    end
                end
                SUB:
                begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd15)
                        fsm <= MIX;
                end
                MIX:
                begin
                    if (round_q == aes_pkg::AES_ROUNDS)
                    begin
                        done_q <= 1'b1;
                        fsm    <= IDLE;
                    end
                    else
                    begin
                        round_q <= round_q + 4'd1;
                        fsm     <= SUB;
                    end
                end
                default:
                    fsm <= IDLE;
            endcase
        end
    end

    // State block, initial AddRoundKey uses the first key half directly
    always_ff @(posedge clk)
    begin
        if (fsm == IDLE && req.start)
            blk <= req.block ^ req.key[255:128];
        else if (fsm == SUB)
            blk[{cnt, 3'b000} +: 8] <= aes_pkg::sbox(blk[{cnt, 3'b000} +: 8]);
        else if (fsm == MIX)
            blk <= mix_out;
    end

    assign busy      = (fsm != IDLE);
    assign rsp.done  = done_q;
    assign rsp.block = blk;

endmodule

`default_nettype wire

//--- tb.f
logic/aes_pkg.sv
logic/aes_host_pkg.sv
logic/aes_cmd_decode.sv
logic/aes_key_expand.sv
logic/aes_round_exec.sv
logic/aes_result_reg.sv
logic/aes256_enc.sv
verif/aes256_enc_tb.sv

//--- verif/aes256_enc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module aes256_enc_tb;

    localparam int CLK_PERIOD = 20;
    localparam int TEST_COUNT = 5;
    localparam int DONE_BOUND = 260;

    // FIPS-197 C.3 vector with key bytes 00..0f in the high half
    localparam aes_pkg::aes_block_t KEY_HI = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::aes_block_t KEY_LO = 128'h101112131415161718191a1b1c1d1e1f;
    localparam aes_pkg::aes_block_t PLAIN  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::aes_block_t CIPHER = 128'h8ea2b7ca516745bfeafc49904b496089;

    logic                      clk;
    logic                      rst;
    logic                      wr_en;
    aes_host_pkg::host_addr_t  addr;
    aes_host_pkg::flag_pos_t   pos;
    logic                      flag_val;
    aes_pkg::aes_block_t       wdata;
    aes_pkg::aes_block_t       ciphertext;
    logic                      done;
    logic                      busy;
    logic                      irq;
    aes_host_pkg::ctrl_flags_t flags;
    logic [31:0]               lfsr_q;
    aes_host_pkg::ctrl_flags_t flags_model;

    aes256_enc dut
    (
        .clk(clk), .rst(rst), .wr_en(wr_en), .addr(addr), .pos(pos),
        .flag_val(flag_val), .wdata(wdata), .ciphertext(ciphertext),
        .done(done), .busy(busy), .irq(irq), .flags(flags)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Budget of 300 cycles per test plus reset and slack
    initial
    begin
        #((TEST_COUNT * 300 + 500) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        abort_run();
    end

    task automatic check_block(input string name, input aes_pkg::aes_block_t got,
                               input aes_pkg::aes_block_t exp);
        if (got !== exp)
        begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flags(input string name, input aes_host_pkg::ctrl_flags_t got,
                               input aes_host_pkg::ctrl_flags_t exp);
        if (got !== exp)
        begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits = {bits[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // One-cycle host write that the DUT samples at the second edge
    task automatic host_write(input aes_host_pkg::host_addr_t a, input aes_host_pkg::flag_pos_t p,
                              input logic v, input aes_pkg::aes_block_t d);
        @(posedge clk);
        wr_en    <= 1'b1;
        addr     <= a;
        pos      <= p;
        flag_val <= v;
        wdata    <= d;
        @(posedge clk);
        wr_en    <= 1'b0;
    endtask

    // Positions past bit 4 select no flag
    task automatic write_flag(input aes_host_pkg::flag_pos_t p, input logic v);
        host_write(aes_host_pkg::ADDR_FLAGS, p, v, '0);
        if (p < 3'd5)
            flags_model[p] = v;
        @(negedge clk);
        check_flags("flags", flags, flags_model);
    endtask

    task automatic write_key(input aes_pkg::aes_block_t hi, input aes_pkg::aes_block_t lo);
        host_write(aes_host_pkg::ADDR_KEY_HI, '0, 1'b0, hi);
        host_write(aes_host_pkg::ADDR_KEY_LO, '0, 1'b0, lo);
    endtask

    task automatic write_plain(input aes_pkg::aes_block_t d);
        host_write(aes_host_pkg::ADDR_PLAIN, '0, 1'b0, d);
    endtask

    task automatic wait_busy(input int bound);
        for (int n = 0; busy !== 1'b1; n++)
        begin
            if (n == bound)
            begin
                $display("Busy did not rise within %0d cycles of a start", bound);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_done(input int bound);
        for (int n = 0; done !== 1'b1; n++)
        begin
            if (n == bound)
            begin
                $display("Done did not rise within %0d cycles", bound);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    // Start the block and confirm the previous done level was cleared
    task automatic start_block(input aes_pkg::aes_block_t d);
        write_plain(d);
        wait_busy(4);
        check_bit("done", done, 1'b0);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("irq", irq, 1'b0);
        check_flags("flags", flags, '0);
        check_block("ciphertext", ciphertext, '0);
    endtask

    task automatic test_known_answer();
        write_flag(aes_host_pkg::FLAG_ENABLE, 1'b1);
        write_key(KEY_HI, KEY_LO);
        start_block(PLAIN);
        wait_done(DONE_BOUND);
        check_block("ciphertext", ciphertext, CIPHER);
        check_bit("busy", busy, 1'b0);
    endtask

    // The known-answer result stays in place while the core is disabled
    task automatic test_flags();
        logic [31:0] bits;
        logic [31:0] val;
        for (int i = 0; i < 16; i++)
        begin
            take_bits(3, bits);
            take_bits(1, val);
            write_flag(bits[2:0], val[0]);
        end
        write_flag(aes_host_pkg::FLAG_ENABLE, 1'b0);
        write_plain(128'h0f1e2d3c4b5a69788796a5b4c3d2e1f0);
        repeat (20)
        begin
            @(negedge clk);
            check_bit("busy", busy, 1'b0);
            check_bit("done", done, 1'b1);
            check_block("ciphertext", ciphertext, CIPHER);
        end
    endtask

    // irq may only show in the cycle where done first rises
    task automatic run_irq_watch(input logic expect_irq);
        start_block(PLAIN);
        for (int n = 0; done !== 1'b1; n++)
        begin
            check_bit("irq", irq, 1'b0);
            if (n == DONE_BOUND)
            begin
                $display("Done did not rise within %0d cycles", DONE_BOUND);
                abort_run();
            end
            @(negedge clk);
        end
        check_bit("irq", irq, expect_irq);
        check_block("ciphertext", ciphertext, CIPHER);
        repeat (4)
        begin
            @(negedge clk);
            check_bit("irq", irq, 1'b0);
            check_bit("done", done, 1'b1);
        end
    endtask

    task automatic test_interrupt();
        write_flag(aes_host_pkg::FLAG_ENABLE, 1'b1);
        write_flag(aes_host_pkg::FLAG_IRQ_EN, 1'b1);
        run_irq_watch(1'b1);
        write_flag(aes_host_pkg::FLAG_IRQ_EN, 1'b0);
        run_irq_watch(1'b0);
    endtask

    task automatic test_busy_protect();
        start_block(PLAIN);
        write_plain(128'hffeeddccbbaa99887766554433221100);
        host_write(aes_host_pkg::ADDR_KEY_HI, '0, 1'b0, 128'h5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a);
        @(negedge clk);
        check_bit("busy", busy, 1'b1);
        wait_done(DONE_BOUND);
        check_block("ciphertext", ciphertext, CIPHER);
        host_write(aes_host_pkg::ADDR_KEY_HI, '0, 1'b0, KEY_HI);
        start_block(PLAIN);
        wait_done(DONE_BOUND);
        check_block("ciphertext", ciphertext, CIPHER);
    endtask

    initial
    begin
        rst         = 1'b1;
        wr_en       = 1'b0;
        addr        = aes_host_pkg::ADDR_FLAGS;
        pos         = '0;
        flag_val    = 1'b0;
        wdata       = '0;
        lfsr_q      = 32'h3529_fcd4;
        flags_model = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_known_answer();
        test_flags();
        test_interrupt();
        test_busy_protect();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
